// File: vlog.f
hw/slave_pkg.sv
hw/frame_decoder.sv
hw/write_collector.sv
hw/link_sender.sv
hw/read_returner.sv
hw/uart_slave.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv

// File: Makefile
TOP = tb_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_top.sv
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DW = 16;
    localparam int ACK_TO = 20;
    localparam int RETX = 2;
    localparam int FRAME_BITS = 6;
    localparam int WRITE_WAIT = (RETX + 1) * (ACK_TO + 4) + 40;
    // six transfers, each sized for the worst write
    localparam int CYCLE_LIMIT = 6 * (FRAME_BITS + DW + WRITE_WAIT);
    localparam int REPLY_NONE = 0;
    localparam int REPLY_ACK = 1;
    localparam int REPLY_NAK = 2;
    localparam int REPLY_SILENT = 3;

    logic          clk, rstN;
    logic          control, valid, wD, ready, rD, rd_valid;
    logic          g_txStart, g_txReady, g_rxDone;
    logic          s_txStart, s_txReady, s_rxDone;
    logic [DW-1:0] g_byteForTx, g_byteFromRx, s_byteForTx, s_byteFromRx;
    logic [DW-1:0] exp_word;
    logic [DW+3:0] exp_stream;
    logic          quiet, write_end, reply_due;
    logic [31:0]   lfsr;
    int            exp_tx_pulses, reply_kind, last_reply;
    int            check_errors;
    int            drv_errors;
    int            cycles = 0;

    tb_clock u_clock (.clk, .rstN);

    uart_slave #(
        .DATA_WIDTH(DW),
        .SLAVE_ID(1),
        .ACK_TIMEOUT(ACK_TO),
        .RETRANSMIT_TIMES(RETX)
    ) DUT (
        .clk, .rstN, .control, .valid, .wD, .ready, .rD, .rd_valid,
        .g_txStart, .g_byteForTx, .g_txReady, .g_rxDone, .g_byteFromRx,
        .s_txStart, .s_byteForTx, .s_txReady, .s_rxDone, .s_byteFromRx
    );

    tb_checker #(.DW(DW)) u_checker (
        .clk, .rstN, .ready, .rD, .rd_valid, .g_txStart, .g_byteForTx,
        .s_txStart, .s_byteForTx, .exp_word, .exp_stream, .exp_tx_pulses,
        .quiet, .write_end, .errors(check_errors)
    );

    // status is the upper nibble of the reply, ack 8'hCC and nak 8'hAA
    function automatic logic [3:0] expected_status(input int kind);
        case (kind)
            REPLY_ACK: return 4'b1100;
            REPLY_NAK, REPLY_SILENT: return 4'b1010;
            default: return 4'b0000;
        endcase
    endfunction

    function automatic logic [DW+3:0] expected_stream(input int kind, input logic [DW-1:0] w);
        return {expected_status(kind), w};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_word(output logic [DW-1:0] w);
        w = '0;
        for (int i = 0; i < DW; i++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[DW-2:0], lfsr[0]};
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic send_frame(input logic [5:0] frame);
        for (int i = 5; i >= 0; i--) begin
            control = frame[i];
            idle(1);
        end
        control = 1'b0;
    endtask

    // msb first, one cycle with valid low in the middle of the word
    task automatic write_bits(input logic [DW-1:0] w);
        int   idx;
        int   waited;
        logic taken;
        logic stalled;
        idx = DW - 1;
        waited = 0;
        stalled = 1'b0;
        while (idx >= 0 && waited < 4 * DW) begin
            if (idx == DW / 2 && !stalled) begin
                valid = 1'b0;
                stalled = 1'b1;
            end else begin
                valid = 1'b1;
                wD = w[idx];
            end
            // ready is stable until the next edge
            taken = ready && valid;
            idle(1);
            if (taken) begin
                idx--;
            end
            waited++;
        end
        valid = 1'b0;
        wD = 1'b0;
        if (idx >= 0) begin
            $display("write word not taken, ready stayed low");
            drv_errors++;
        end
    endtask

    task automatic prev_board_word(input logic [DW-1:0] w);
        idle(2);
        g_byteFromRx = w;
        g_rxDone = 1'b1;
        idle(1);
        g_rxDone = 1'b0;
    endtask

    task automatic do_write(input int kind);
        logic [DW-1:0] w;
        int            n;
        draw_word(w);
        exp_word = w;
        reply_kind = kind;
        exp_tx_pulses = (kind == REPLY_SILENT) ? RETX + 1 : 1;
        send_frame({3'b111, 2'd1, 1'b1});
        write_bits(w);
        n = 0;
        while (DUT.write_done !== 1'b1 && n < WRITE_WAIT) begin
            idle(1);
            n++;
        end
        if (DUT.write_done !== 1'b1) begin
            $display("write to the next board never completed");
            drv_errors++;
        end
        write_end = 1'b1;
        idle(1);
        write_end = 1'b0;
        last_reply = kind;
        idle(2);
    endtask

    task automatic do_read();
        logic [DW-1:0] g;
        int            n;
        logic          seen;
        send_frame({3'b111, 2'd1, 1'b0});
        draw_word(g);
        exp_stream = expected_stream(last_reply, g);
        prev_board_word(g);
        n = 0;
        seen = 1'b0;
        while (!(seen && !rd_valid) && n < 2 * (DW + 4)) begin
            seen = seen | rd_valid;
            idle(1);
            n++;
        end
        if (!(seen && !rd_valid)) begin
            $display("read burst on rD never finished");
            drv_errors++;
        end
        idle(2);
    endtask

    // foreign id on a read, then bad start code on a write
    task automatic reject_frames();
        logic [DW-1:0] g;
        quiet = 1'b1;
        send_frame({3'b111, 2'd2, 1'b0});
        draw_word(g);
        prev_board_word(g);
        idle(4);
        send_frame({3'b101, 2'd1, 1'b1});
        valid = 1'b1;
        wD = 1'b1;
        idle(4);
        valid = 1'b0;
        wD = 1'b0;
        idle(2);
        quiet = 1'b0;
    endtask

    // next board answers one cycle after each start, unless silent
    initial begin
        s_rxDone = 1'b0;
        s_byteFromRx = '0;
        reply_due = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            s_rxDone = reply_due;
            if (reply_due) begin
                s_byteFromRx = (reply_kind == REPLY_ACK) ? DW'(8'hCC) : DW'(8'hAA);
            end
            reply_due = s_txStart && (reply_kind != REPLY_SILENT);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("errors: %0d checker, %0d driver", check_errors, drv_errors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        control = 1'b0;
        valid = 1'b0;
        wD = 1'b0;
        g_txReady = 1'b1;
        g_rxDone = 1'b0;
        g_byteFromRx = '0;
        s_txReady = 1'b1;
        quiet = 1'b0;
        write_end = 1'b0;
        exp_word = '0;
        exp_stream = '0;
        exp_tx_pulses = 0;
        reply_kind = REPLY_NONE;
        last_reply = REPLY_NONE;
        lfsr = 32'he3785c36;
        drv_errors = 0;
        @(posedge rstN);
        idle(1);
        do_read();
        do_write(REPLY_ACK);
        do_read();
        do_write(REPLY_NAK);
        do_read();
        do_write(REPLY_SILENT);
        do_read();
        reject_frames();
        do_write(REPLY_ACK);
        do_read();
        idle(4);
        $display("errors: %0d checker, %0d driver", check_errors, drv_errors);
        if (check_errors == 0 && drv_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: bench/tb_checker.sv
module tb_checker #(
    parameter int DW = 16
) (
    input  logic          clk,
    input  logic          rstN,
    input  logic          ready,
    input  logic          rD,
    input  logic          rd_valid,
    input  logic          g_txStart,
    input  logic [DW-1:0] g_byteForTx,
    input  logic          s_txStart,
    input  logic [DW-1:0] s_byteForTx,
    input  logic [DW-1:0] exp_word,
    input  logic [DW+3:0] exp_stream,
    input  int            exp_tx_pulses,
    input  logic          quiet,
    input  logic          write_end,
    output int            errors
);
    timeunit 1ns;
    timeprecision 100ps;

    // reply to the previous board is the ack byte, zero extended
    localparam logic [DW-1:0] ACK_REPLY = DW'(8'hCC);

    logic [DW+3:0] stream = '0;
    int            bits_seen = 0;
    int            tx_pulses = 0;
    int            ack_pulses = 0;
    int            err_count = 0;
    logic          was_valid = 1'b0;

    assign errors = err_count;

    // mid cycle, DUT outputs and bench drives have settled
    always @(negedge clk) begin
        if (rstN) begin
            if (s_txStart) begin
                tx_pulses++;
                if (s_byteForTx !== exp_word) begin
                    $display("Fail s_byteForTx: got %h expected %h", s_byteForTx, exp_word);
                    err_count++;
                end
            end
            if (write_end) begin
                if (tx_pulses != exp_tx_pulses) begin
                    $display("word went to the next board %0d times, expected %0d times",
                             tx_pulses, exp_tx_pulses);
                    err_count++;
                end
                tx_pulses = 0;
            end
            if (g_txStart) begin
                ack_pulses++;
                if (g_byteForTx !== ACK_REPLY) begin
                    $display("Fail g_byteForTx: got %h expected %h", g_byteForTx, ACK_REPLY);
                    err_count++;
                end
            end
            if (rd_valid) begin
                stream = {stream[DW+2:0], rD};
                bits_seen++;
            end else if (was_valid) begin
                // burst on rD just ended
                if (bits_seen != DW + 4) begin
                    $display("rd_valid burst lasted %0d cycles instead of %0d",
                             bits_seen, DW + 4);
                    err_count++;
                end else if (stream !== exp_stream) begin
                    $display("Fail rD: got %h expected %h", stream, exp_stream);
                    err_count++;
                end
                if (ack_pulses != 1) begin
                    $display("read gave %0d ack pulses to the previous board", ack_pulses);
                    err_count++;
                end
                bits_seen = 0;
                ack_pulses = 0;
            end
            was_valid = rd_valid;
            if (quiet && (ready || s_txStart || g_txStart)) begin
                $display("slave reacted to a frame it should have dropped");
                err_count++;
            end
        end
    end

endmodule

// File: bench/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 20
) (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // two full cycles in reset, released just after an edge
    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        #2 rstN = 1'b1;
    end

endmodule

// File: hw/uart_slave.sv
module uart_slave #(
    parameter int DATA_WIDTH       = 32,
    parameter int SLAVE_ID         = 1,
    parameter int ACK_TIMEOUT      = 1000000,
    parameter int RETRANSMIT_TIMES = 5
) (
    input  logic                  clk,
    input  logic                  rstN,
    // master side
    input  logic                  control,
    input  logic                  valid,
    input  logic                  wD,
    output logic                  ready,
    output logic                  rD,
    output logic                  rd_valid,
    // previous board
    output logic                  g_txStart,
    output logic [DATA_WIDTH-1:0] g_byteForTx,
    input  logic                  g_txReady,
    input  logic                  g_rxDone,
    input  logic [DATA_WIDTH-1:0] g_byteFromRx,
    // next board
    output logic                  s_txStart,
    output logic [DATA_WIDTH-1:0] s_byteForTx,
    input  logic                  s_txReady,
    input  logic                  s_rxDone,
    input  logic [DATA_WIDTH-1:0] s_byteFromRx
);
    slave_pkg::cmd_t       cmd;
    slave_pkg::status_t    status;
    logic                  word_strobe;
    logic [DATA_WIDTH-1:0] word;
    logic                  write_done;
    logic                  read_done;

    frame_decoder #(.SLAVE_ID(SLAVE_ID)) u_frame_decoder (
        .clk, .rstN, .control, .write_done, .read_done, .cmd
    );

    write_collector #(.DATA_WIDTH(DATA_WIDTH)) u_write_collector (
        .clk, .rstN, .cmd, .valid, .wD, .ready, .word_strobe, .word
    );

    link_sender #(
        .DATA_WIDTH(DATA_WIDTH),
        .ACK_TIMEOUT(ACK_TIMEOUT),
        .RETRANSMIT_TIMES(RETRANSMIT_TIMES)
    ) u_link_sender (
        .clk, .rstN, .word_strobe, .word, .s_txReady, .s_rxDone, .s_byteFromRx,
        .s_txStart, .s_byteForTx, .status, .write_done
    );

    read_returner #(.DATA_WIDTH(DATA_WIDTH)) u_read_returner (
        .clk, .rstN, .cmd, .g_rxDone, .g_byteFromRx, .g_txReady, .status,
        .g_txStart, .g_byteForTx, .rD, .rd_valid, .read_done
    );

endmodule

// File: hw/read_returner.sv
module read_returner #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  slave_pkg::cmd_t       cmd,
    input  logic                  g_rxDone,
    input  logic [DATA_WIDTH-1:0] g_byteFromRx,
    input  logic                  g_txReady,
    input  slave_pkg::status_t    status,
    output logic                  g_txStart,
    output logic [DATA_WIDTH-1:0] g_byteForTx,
    output logic                  rD,
    output logic                  rd_valid,
    output logic                  read_done
);
    // status nibble ahead of the data word
    localparam int OUT_LEN = 4 + DATA_WIDTH;
    localparam int CNT_W   = $clog2(OUT_LEN);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(OUT_LEN - 1);

    localparam logic [1:0] IDLE     = 2'd0;
    localparam logic [1:0] WAIT_RX  = 2'd1;
    localparam logic [1:0] SEND_ACK = 2'd2;
    localparam logic [1:0] SHIFT    = 2'd3;

    logic [1:0]         state;
    logic [CNT_W-1:0]   bit_cnt;
    logic [OUT_LEN-1:0] sreg;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= IDLE;
            g_txStart <= 1'b0;
            rd_valid  <= 1'b0;
            read_done <= 1'b0;
            bit_cnt   <= '0;
        end else begin
            g_txStart <= 1'b0;
            read_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd.go && !cmd.write) begin
                        state <= WAIT_RX;
                    end
                end
                WAIT_RX: begin
                    if (g_rxDone) begin
                        state <= SEND_ACK;
                    end
                end
                SEND_ACK: begin
                    if (g_txReady) begin
                        g_txStart <= 1'b1;
                        bit_cnt   <= '0;
                        state     <= SHIFT;
                    end
                end
                SHIFT: begin
                    // first cycle here is the ack start, output follows
                    if (!rd_valid) begin
                        rd_valid <= 1'b1;
                    end else if (bit_cnt == LAST_BIT) begin
                        rd_valid  <= 1'b0;
                        read_done <= 1'b1;
                        state     <= IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WAIT_RX && g_rxDone) begin
            sreg <= {status, g_byteFromRx};
        end else if (rd_valid) begin
            sreg <= {sreg[OUT_LEN-2:0], 1'b0};
        end
    end

    assign rD          = rd_valid & sreg[OUT_LEN-1];
    assign g_byteForTx = DATA_WIDTH'(slave_pkg::ACK_BYTE);

    ack_before_data: assert property (@(posedge clk) disable iff (!rstN)
        !(g_txStart && rd_valid));

endmodule

// File: hw/link_sender.sv
module link_sender #(
    parameter int DATA_WIDTH       = 32,
    parameter int ACK_TIMEOUT      = 1000000,
    parameter int RETRANSMIT_TIMES = 5
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  word_strobe,
    input  logic [DATA_WIDTH-1:0] word,
    input  logic                  s_txReady,
    input  logic                  s_rxDone,
    input  logic [DATA_WIDTH-1:0] s_byteFromRx,
    output logic                  s_txStart,
    output logic [DATA_WIDTH-1:0] s_byteForTx,
    output slave_pkg::status_t    status,
    output logic                  write_done
);
    localparam int TIMER_W = $clog2(ACK_TIMEOUT + 1);
    localparam int RETX_W  = $clog2(RETRANSMIT_TIMES + 1);
    localparam logic [TIMER_W-1:0]    TIMER_LAST = TIMER_W'(ACK_TIMEOUT - 1);
    localparam logic [RETX_W-1:0]     RETX_LAST  = RETX_W'(RETRANSMIT_TIMES);
    localparam logic [DATA_WIDTH-1:0] ACK_WORD   = DATA_WIDTH'(slave_pkg::ACK_BYTE);

    localparam logic [1:0] IDLE       = 2'd0;
    localparam logic [1:0] WAIT_TX    = 2'd1;
    localparam logic [1:0] WAIT_REPLY = 2'd2;

    logic [1:0]         state;
    logic [TIMER_W-1:0] timer;
    logic [RETX_W-1:0]  retx_cnt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= IDLE;
            s_txStart  <= 1'b0;
            write_done <= 1'b0;
            timer      <= '0;
            retx_cnt   <= '0;
            status     <= slave_pkg::STATUS_NONE;
        end else begin
            s_txStart  <= 1'b0;
            write_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (word_strobe) begin
                        retx_cnt <= '0;
                        state    <= WAIT_TX;
                    end
                end
                WAIT_TX: begin
                    if (s_txReady) begin
                        s_txStart <= 1'b1;
                        timer     <= '0;
                        state     <= WAIT_REPLY;
                    end
                end
                WAIT_REPLY: begin
                    if (s_rxDone) begin
                        // anything but the ack byte counts as nak
                        status     <= (s_byteFromRx == ACK_WORD) ? slave_pkg::STATUS_ACK
                                                                 : slave_pkg::STATUS_NAK;
                        write_done <= 1'b1;
                        state      <= IDLE;
                    end else if (timer == TIMER_LAST) begin
                        if (retx_cnt == RETX_LAST) begin
                            // give up, silent link
                            status     <= slave_pkg::STATUS_NAK;
                            write_done <= 1'b1;
                            state      <= IDLE;
                        end else begin
                            retx_cnt <= retx_cnt + 1'b1;
                            state    <= WAIT_TX;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // word kept for every retransmit
    always_ff @(posedge clk) begin
        if (word_strobe) begin
            s_byteForTx <= word;
        end
    end

    tx_start_with_ready: assert property (@(posedge clk) disable iff (!rstN)
        s_txStart |-> s_txReady);

endmodule

// File: hw/write_collector.sv
module write_collector #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  slave_pkg::cmd_t       cmd,
    input  logic                  valid,
    input  logic                  wD,
    output logic                  ready,
    output logic                  word_strobe,
    output logic [DATA_WIDTH-1:0] word
);
    localparam int CNT_W = $clog2(DATA_WIDTH);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DATA_WIDTH - 1);

    logic [CNT_W-1:0]      bit_cnt;
    logic [DATA_WIDTH-1:0] shift;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ready       <= 1'b0;
            word_strobe <= 1'b0;
            bit_cnt     <= '0;
        end else begin
            word_strobe <= 1'b0;
            if (cmd.go && cmd.write) begin
                ready   <= 1'b1;
                bit_cnt <= '0;
            end else if (ready && valid) begin
                if (bit_cnt == LAST_BIT) begin
                    // word complete, shift register now holds it
                    ready       <= 1'b0;
                    word_strobe <= 1'b1;
                    bit_cnt     <= '0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // msb first
    always_ff @(posedge clk) begin
        if (ready && valid) begin
            shift <= {shift[DATA_WIDTH-2:0], wD};
        end
    end

    assign word = shift;

endmodule

// File: hw/frame_decoder.sv
module frame_decoder #(
    parameter int SLAVE_ID = 1
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              control,
    input  logic              write_done,
    input  logic              read_done,
    output slave_pkg::cmd_t   cmd
);
    localparam int CNT_W = $clog2(slave_pkg::FRAME_LEN);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(slave_pkg::FRAME_LEN - 1);

    slave_pkg::ctrl_frame_u frame;
    slave_pkg::ctrl_frame_u frame_next;
    logic                   collecting;
    logic                   busy;
    logic [CNT_W-1:0]       bit_cnt;
    logic                   frame_hit;

    // frame as it stands once the current control bit is in
    assign frame_next.raw = {frame.raw[slave_pkg::FRAME_LEN-2:0], control};
    assign frame_hit = (frame_next.fields.start == slave_pkg::START_CODE) &&
                       (int'(frame_next.fields.id) == SLAVE_ID);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            collecting <= 1'b0;
            busy       <= 1'b0;
            bit_cnt    <= '0;
            cmd        <= '0;
        end else begin
            cmd.go <= 1'b0;
            if (write_done || read_done) begin
                busy <= 1'b0;
            end
            if (collecting) begin
                if (bit_cnt == LAST_BIT) begin
                    collecting <= 1'b0;
                    // bad start or foreign id is dropped silently
                    if (frame_hit) begin
                        cmd.go    <= 1'b1;
                        cmd.write <= frame_next.fields.rw;
                        busy      <= 1'b1;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (control && !busy) begin
                collecting <= 1'b1;
                bit_cnt    <= CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (collecting || (control && !busy)) begin
            frame <= frame_next;
        end
    end

    go_single_pulse: assert property (@(posedge clk) disable iff (!rstN) cmd.go |=> !cmd.go);

endmodule

// File: hw/slave_pkg.sv
package slave_pkg;

    // id field of 2 bits gives three slaves plus the free code 0
    localparam int S_ID_WIDTH = 2;
    localparam logic [2:0] START_CODE = 3'b111;

    // start code, slave id, rw bit
    localparam int FRAME_LEN = 3 + S_ID_WIDTH + 1;

    localparam logic [7:0] ACK_BYTE = 8'hCC;
    localparam logic [7:0] NAK_BYTE = 8'hAA;

    typedef struct packed {
        logic [2:0]            start;
        logic [S_ID_WIDTH-1:0] id;
        logic                  rw;
    } ctrl_fields_t;

    // raw while shifting, fields once the frame is complete
    typedef union packed {
        logic [FRAME_LEN-1:0] raw;
        ctrl_fields_t         fields;
    } ctrl_frame_u;

    typedef struct packed {
        logic go;
        logic write;
    } cmd_t;

    // upper nibble of the reply byte
    typedef logic [3:0] status_t;
    localparam status_t STATUS_NONE = 4'b0000;
    localparam status_t STATUS_ACK  = ACK_BYTE[7:4];
    localparam status_t STATUS_NAK  = NAK_BYTE[7:4];

endpackage
